// ==== Makefile ====
# Verilator build and run of the cartridge and host control testbench

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_core_top -o tb_core_top
	@out=$$(./obj_dir/tb_core_top); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== logic/cart_quirk_lookup.sv ====
/*
 * Per-title quirk and light gun lookup.
 * Matches the snooped cartridge id against a small title table and
 * registers the result on the id_valid pulse.
 */
`default_nettype none

module cart_quirk_lookup (
    input  wire                                  clk_74a,
    input  wire                                  pll_core_locked,
    input  wire                                  cart_download,
    input  wire [core_pkg::CART_ID_W-1:0]        cart_id,
    input  wire                                  id_valid,
    output logic [core_pkg::QUIRK_W-1:0]         quirk_flags,
    output logic                                 gun_type,
    output logic [core_pkg::GUN_DELAY_W-1:0]     gun_delay
);
    import core_pkg::*;

    logic                   id_hit;     // id seen in this download
    logic                   gun_type_nxt;
    logic [GUN_DELAY_W-1:0] gun_delay_nxt;

    // one title per quirk, ids padded with spaces
    function automatic logic [QUIRK_W-1:0] quirk_of(input logic [CART_ID_W-1:0] id);
        logic [QUIRK_W-1:0] q;
        q = '0;
        case (id)
            "T-081276": q[Q_SRAM]   = 1'b1;
            " GM 0000": q[Q_SRAM00] = 1'b1;
            "G-4060  ": q[Q_EEPROM] = 1'b1;
            "T-113016": q[Q_NORAM]  = 1'b1;   // fake ram check
            "T-89016 ": q[Q_FIFO]   = 1'b1;
            "T-574023": q[Q_PIER]   = 1'b1;
            "MK-1229 ": q[Q_SVP]    = 1'b1;
            "T-35036 ": q[Q_FMBUSY] = 1'b1;
            "T-68???-": q[Q_SCHAN]  = 1'b1;
            default:    ;
        endcase
        return q;
    endfunction

    // light gun type and sensor timing
    always_comb begin
        gun_type_nxt  = 1'b0;
        gun_delay_nxt = GUN_DELAY_DEFAULT;
        case (cart_id)
            "MK-1533 ": gun_delay_nxt = 8'd100;
            "T-95096-": begin
                gun_type_nxt  = 1'b1;
                gun_delay_nxt = 8'd52;
            end
            "T-95136-": begin
                gun_type_nxt  = 1'b1;
                gun_delay_nxt = 8'd30;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            id_hit      <= 1'b0;
            quirk_flags <= '0;
            gun_type    <= 1'b0;
            gun_delay   <= GUN_DELAY_DEFAULT;
        end else begin
            if (!cart_download) begin
                id_hit <= 1'b0;
            end
            if (id_valid) begin
                id_hit      <= 1'b1;
                quirk_flags <= quirk_of(cart_id);
                gun_type    <= gun_type_nxt;
                gun_delay   <= gun_delay_nxt;
            end else if (cart_download && !id_hit) begin
                quirk_flags <= '0;  // no stale quirks while loading
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/core_pkg.sv ====
/*
 * Shared constants for the cartridge and host control logic.
 * Covers the bridge map, header offsets, quirk bit positions and pad widths.
 * Compile first. Modules import it inside their bodies.
 */
`default_nettype none

package core_pkg;

    ////////////////////////////////////////
    // bridge and rom stream

    localparam int BRIDGE_W   = 32;
    localparam int ROM_ADDR_W = 25;   // byte address
    localparam int ROM_DATA_W = 16;

    localparam logic [BRIDGE_W-1:0] ADDR_REGION     = 32'h00E0_0000; // read back
    localparam logic [BRIDGE_W-1:0] ADDR_TURBO      = 32'h00C0_0000;
    localparam logic [BRIDGE_W-1:0] ADDR_MULTITAP   = 32'h0000_0000;
    localparam logic [BRIDGE_W-1:0] ADDR_RESET_REQ  = 32'h0000_0070;
    localparam logic [BRIDGE_W-1:0] ADDR_M30_MAP    = 32'h0000_0080;
    localparam logic [BRIDGE_W-1:0] ADDR_MENU_PAUSE = 32'h0000_0090;
    localparam logic [BRIDGE_W-1:0] ADDR_LIGHTGUN   = 32'h0000_0100;

    ////////////////////////////////////////
    // cartridge header, word offsets

    localparam logic [ROM_ADDR_W-1:0] HDR_ID0     = 25'h182; // only the odd byte is id
    localparam logic [ROM_ADDR_W-1:0] HDR_ID1     = 25'h184;
    localparam logic [ROM_ADDR_W-1:0] HDR_ID2     = 25'h186;
    localparam logic [ROM_ADDR_W-1:0] HDR_ID3     = 25'h188;
    localparam logic [ROM_ADDR_W-1:0] HDR_ID4     = 25'h18A; // even byte only
    localparam logic [ROM_ADDR_W-1:0] HDR_ID_DONE = 25'h18C;
    localparam logic [ROM_ADDR_W-1:0] HDR_REGION0 = 25'h1F0;
    localparam logic [ROM_ADDR_W-1:0] HDR_REGION1 = 25'h1F2;
    localparam logic [ROM_ADDR_W-1:0] HDR_END     = 25'h200;

    ////////////////////////////////////////
    // region, quirks, light gun

    localparam int CART_ID_W = 64;    // eight ascii chars
    localparam int REGION_W  = 2;
    localparam logic [REGION_W-1:0] REGION_JP = 2'd0;
    localparam logic [REGION_W-1:0] REGION_US = 2'd1;
    localparam logic [REGION_W-1:0] REGION_EU = 2'd2;

    localparam int QUIRK_W  = 9;
    localparam int Q_SRAM   = 0;
    localparam int Q_SRAM00 = 1;
    localparam int Q_EEPROM = 2;
    localparam int Q_NORAM  = 3;
    localparam int Q_FIFO   = 4;
    localparam int Q_PIER   = 5;
    localparam int Q_SVP    = 6;
    localparam int Q_FMBUSY = 7;
    localparam int Q_SCHAN  = 8;

    localparam int GUN_DELAY_W = 8;
    localparam logic [GUN_DELAY_W-1:0] GUN_DELAY_DEFAULT = 8'd44;

    localparam int RST_CNT_W   = 12;
    localparam int RST_DELAY_W = RST_CNT_W + 4;   // counter plus four fill ones

    ////////////////////////////////////////
    // pads

    localparam int PAD_W = 12;
    localparam int KEY_W = 16;

    // one header byte, seen as a letter or as two hex nibbles
    typedef union packed {
        logic [7:0]      as_char;
        logic [1:0][3:0] as_digit;   // [1] high, [0] low = region mask
    } hdr_byte_u;

endpackage

`default_nettype wire

// ==== logic/core_settings.sv ====
/*
 * Core settings registers on the bridge bus.
 * Also runs the host reset delay and drives the console reset and pause.
 */
`default_nettype none

module core_settings (
    input  wire                               clk_74a,
    input  wire                               pll_core_locked,
    input  wire [core_pkg::BRIDGE_W-1:0]      bridge_addr,
    input  wire                               bridge_wr,
    input  wire [core_pkg::BRIDGE_W-1:0]      bridge_wr_data,
    input  wire [core_pkg::REGION_W-1:0]      region_req,
    input  wire                               region_set,
    input  wire                               osnotify_inmenu,
    output logic [core_pkg::BRIDGE_W-1:0]     bridge_rd_data,
    output logic [1:0]                        cpu_turbo,
    output logic                              multitap_en,
    output logic                              m30_map_en,
    output logic                              lightgun_en,
    output logic                              core_reset_n,
    output logic                              pause_en
);
    import core_pkg::*;

    logic [RST_CNT_W-1:0]   reset_counter;  // free running, seeds the delay
    logic [RST_DELAY_W-1:0] reset_delay;
    logic                   menu_pause_en;

    ////////////////////////////////////////
    // settings write decode

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            reset_counter <= '0;
            reset_delay   <= '0;
            cpu_turbo     <= '0;
            multitap_en   <= 1'b0;
            m30_map_en    <= 1'b0;
            lightgun_en   <= 1'b0;
            menu_pause_en <= 1'b0;
        end else begin
            reset_counter <= reset_counter + 1'b1;
            if (!osnotify_inmenu && reset_delay != '0) begin
                reset_delay <= reset_delay - 1'b1;  // frozen while in menu
            end
            if (bridge_wr) begin
                case (bridge_addr)
                    ADDR_TURBO:      cpu_turbo     <= bridge_wr_data[1:0];
                    ADDR_MULTITAP:   multitap_en   <= bridge_wr_data[0];
                    ADDR_M30_MAP:    m30_map_en    <= bridge_wr_data[0];
                    ADDR_MENU_PAUSE: menu_pause_en <= bridge_wr_data[0];
                    ADDR_LIGHTGUN:   lightgun_en   <= bridge_wr_data[0];
                    ADDR_RESET_REQ: begin
                        // low nibble of ones keeps the delay nonzero
                        if (bridge_wr_data != '0) begin
                            reset_delay <= {reset_counter, 4'hF};
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // reset, pause, read back

    assign core_reset_n = !region_set && (reset_delay == '0);
    assign pause_en     = osnotify_inmenu & menu_pause_en;

    always_comb begin
        bridge_rd_data = '0;
        if (bridge_addr == ADDR_REGION) begin
            bridge_rd_data = {{(BRIDGE_W-REGION_W){1'b0}}, region_req};
        end
    end

endmodule

`default_nettype wire

// ==== logic/core_top.sv ====
/*
 * Cartridge and host control top level.
 * Header snoop, quirk lookup, region choice, settings and pad mapping.
 */
`default_nettype none

module core_top (
    input  wire                                  clk_74a,
    input  wire                                  pll_core_locked,
    input  wire [core_pkg::BRIDGE_W-1:0]         bridge_addr,
    input  wire                                  bridge_wr,
    input  wire [core_pkg::BRIDGE_W-1:0]         bridge_wr_data,
    input  wire                                  cart_download,
    input  wire                                  rom_wr,
    input  wire [core_pkg::ROM_ADDR_W-1:0]       rom_addr,
    input  wire [core_pkg::ROM_DATA_W-1:0]       rom_data,
    input  wire                                  osnotify_inmenu,
    input  wire [core_pkg::KEY_W-1:0]            cont1_key,
    input  wire [core_pkg::KEY_W-1:0]            cont2_key,
    input  wire [core_pkg::KEY_W-1:0]            cont3_key,
    input  wire [core_pkg::KEY_W-1:0]            cont4_key,
    output logic [core_pkg::BRIDGE_W-1:0]        bridge_rd_data,
    output logic [core_pkg::REGION_W-1:0]        region_req,
    output logic [core_pkg::QUIRK_W-1:0]         quirk_flags,
    output logic                                 gun_type,
    output logic [core_pkg::GUN_DELAY_W-1:0]     gun_delay,
    output logic                                 core_reset_n,
    output logic                                 pause_en,
    output logic [1:0]                           cpu_turbo,
    output logic                                 multitap_en,
    output logic [core_pkg::PAD_W-1:0]           pad0,
    output logic [core_pkg::PAD_W-1:0]           pad1,
    output logic [core_pkg::PAD_W-1:0]           pad2,
    output logic [core_pkg::PAD_W-1:0]           pad3
);

    logic [core_pkg::CART_ID_W-1:0] cart_id;
    logic id_valid;
    logic hdr_j;
    logic hdr_u;
    logic hdr_e;
    logic hdr_ready;
    logic region_set;
    logic m30_map_en;
    logic lightgun_en;

    rom_header_decode u_hdr (
        .clk_74a, .pll_core_locked, .cart_download, .rom_wr, .rom_addr, .rom_data,
        .cart_id, .id_valid, .hdr_j, .hdr_u, .hdr_e, .hdr_ready
    );

    cart_quirk_lookup u_quirk (
        .clk_74a, .pll_core_locked, .cart_download, .cart_id, .id_valid,
        .quirk_flags, .gun_type, .gun_delay
    );

    region_select u_region (
        .clk_74a, .pll_core_locked, .hdr_j, .hdr_u, .hdr_e, .hdr_ready,
        .region_req, .region_set
    );

    core_settings u_settings (
        .clk_74a, .pll_core_locked, .bridge_addr, .bridge_wr, .bridge_wr_data,
        .region_req, .region_set, .osnotify_inmenu,
        .bridge_rd_data, .cpu_turbo, .multitap_en, .m30_map_en, .lightgun_en,
        .core_reset_n, .pause_en
    );

    pad_mapper u_pads (
        .clk_74a, .pll_core_locked, .cont1_key, .cont2_key, .cont3_key, .cont4_key,
        .m30_map_en, .lightgun_en, .pad0, .pad1, .pad2, .pad3
    );

endmodule

`default_nettype wire

// ==== logic/pad_mapper.sv ====
/*
 * Maps the four host controller key words onto console pad words.
 * Registered, one cycle after the keys, with an alternate six-button layout.
 */
`default_nettype none

module pad_mapper (
    input  wire                            clk_74a,
    input  wire                            pll_core_locked,
    input  wire [core_pkg::KEY_W-1:0]      cont1_key,
    input  wire [core_pkg::KEY_W-1:0]      cont2_key,
    input  wire [core_pkg::KEY_W-1:0]      cont3_key,
    input  wire [core_pkg::KEY_W-1:0]      cont4_key,
    input  wire                            m30_map_en,
    input  wire                            lightgun_en,
    output logic [core_pkg::PAD_W-1:0]     pad0,
    output logic [core_pkg::PAD_W-1:0]     pad1,
    output logic [core_pkg::PAD_W-1:0]     pad2,
    output logic [core_pkg::PAD_W-1:0]     pad3
);
    import core_pkg::*;

    // pad word, msb first: Z Y X mode start B C A up down left right
    function automatic logic [PAD_W-1:0] map_pad(input logic [KEY_W-1:0] k,
                                                 input logic alt,
                                                 input logic start_off);
        logic [PAD_W-1:0] p;
        if (alt)
            p = {k[10], k[7], k[6], k[14], k[15], k[11], k[5], k[4], k[0], k[1], k[2], k[3]};
        else
            p = {k[9], k[6], k[8], k[14], k[15], k[4], k[5], k[7], k[0], k[1], k[2], k[3]};
        if (start_off) begin
            p[7] = 1'b0;    // start
        end
        return p;
    endfunction

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            pad0 <= '0;
            pad1 <= '0;
            pad2 <= '0;
            pad3 <= '0;
        end else begin
            pad0 <= map_pad(cont1_key, m30_map_en, lightgun_en);  // gun owns start
            pad1 <= map_pad(cont2_key, m30_map_en, 1'b0);
            pad2 <= map_pad(cont3_key, m30_map_en, 1'b0);
            pad3 <= map_pad(cont4_key, m30_map_en, 1'b0);
        end
    end

endmodule

`default_nettype wire

// ==== logic/region_select.sv ====
/*
 * Console region choice.
 * Picks the region when the header has passed, and holds region_set
 * until the header flag drops at the end of the download.
 */
`default_nettype none

module region_select (
    input  wire                               clk_74a,
    input  wire                               pll_core_locked,
    input  wire                               hdr_j,
    input  wire                               hdr_u,
    input  wire                               hdr_e,
    input  wire                               hdr_ready,
    output logic [core_pkg::REGION_W-1:0]     region_req,
    output logic                              region_set
);
    import core_pkg::*;

    logic rdy_q;

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            rdy_q      <= 1'b0;
            region_req <= REGION_US;
            region_set <= 1'b0;
        end else begin
            rdy_q <= hdr_ready;
            if (hdr_ready && !rdy_q) begin
                region_set <= 1'b1;
                if (hdr_u)      region_req <= REGION_US;   // US wins
                else if (hdr_e) region_req <= REGION_EU;
                else if (hdr_j) region_req <= REGION_JP;
                else            region_req <= REGION_US;
            end
            if (!hdr_ready && rdy_q) begin
                region_set <= 1'b0;
            end
        end
    end

    // region bytes come before the header end, so the choice sees final flags
    a_flags_stable: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        hdr_ready && rdy_q |-> $stable({hdr_e, hdr_u, hdr_j}));

endmodule

`default_nettype wire

// ==== logic/rom_header_decode.sv ====
/*
 * Snoops ROM download writes for the cartridge header.
 * Builds the eight-character id, the J/U/E region flags and a header-ready flag.
 */
`default_nettype none

module rom_header_decode (
    input  wire                              clk_74a,
    input  wire                              pll_core_locked,
    input  wire                              cart_download,
    input  wire                              rom_wr,
    input  wire [core_pkg::ROM_ADDR_W-1:0]   rom_addr,
    input  wire [core_pkg::ROM_DATA_W-1:0]   rom_data,
    output logic [core_pkg::CART_ID_W-1:0]   cart_id,
    output logic                             id_valid,
    output logic                             hdr_j,
    output logic                             hdr_u,
    output logic                             hdr_e,
    output logic                             hdr_ready
);
    import core_pkg::*;

    logic       hdr_wr;
    logic       dl_q;       // download, one cycle late
    hdr_byte_u  lo_b;       // byte at the even address
    hdr_byte_u  hi_b;
    logic [2:0] lo_jue;     // {E, U, J}
    logic [2:0] hi_jue;
    logic       lo_hex;
    logic [3:0] lo_val;

    function automatic logic [2:0] jue_of(input hdr_byte_u b);
        return {b.as_char == "E", b.as_char == "U", b.as_char == "J"};
    endfunction

    assign hdr_wr = rom_wr & cart_download;
    assign lo_b   = rom_data[7:0];
    assign hi_b   = rom_data[15:8];
    assign lo_jue = jue_of(lo_b);
    assign hi_jue = jue_of(hi_b);
    assign lo_hex = lo_b.as_char inside {["0":"9"], ["A":"F"]};
    // letters A..F carry 1..6 in the low nibble
    assign lo_val = lo_b.as_digit[0] + ((lo_b.as_char >= "A") ? 4'd9 : 4'd0);

    // id bytes come byte swapped, first char lands in the top byte
    always_ff @(posedge clk_74a) begin
        if (hdr_wr) begin
            case (rom_addr)
                HDR_ID0: cart_id[63:56] <= rom_data[15:8];
                HDR_ID1: cart_id[55:40] <= {rom_data[7:0], rom_data[15:8]};
                HDR_ID2: cart_id[39:24] <= {rom_data[7:0], rom_data[15:8]};
                HDR_ID3: cart_id[23:8]  <= {rom_data[7:0], rom_data[15:8]};
                HDR_ID4: cart_id[7:0]   <= rom_data[7:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            dl_q                <= 1'b0;
            id_valid            <= 1'b0;
            {hdr_e, hdr_u, hdr_j} <= 3'b000;
            hdr_ready           <= 1'b0;
        end else begin
            dl_q     <= cart_download;
            id_valid <= hdr_wr && (rom_addr == HDR_ID_DONE);
            if (cart_download && !dl_q) begin
                {hdr_e, hdr_u, hdr_j} <= 3'b000;    // new cart
            end
            if (!cart_download && dl_q) begin
                hdr_ready <= 1'b0;
            end
            if (hdr_wr && rom_addr == HDR_REGION0) begin
                if (|lo_jue)
                    {hdr_e, hdr_u, hdr_j} <= {hdr_e, hdr_u, hdr_j} | lo_jue | hi_jue;
                else if (lo_hex)    // old style hex mask
                    {hdr_e, hdr_u, hdr_j} <= {lo_val[3], lo_val[2], lo_val[0]} | hi_jue;
                else
                    {hdr_e, hdr_u, hdr_j} <= {hdr_e, hdr_u, hdr_j} | hi_jue;
            end
            if (hdr_wr && rom_addr == HDR_REGION1) begin
                {hdr_e, hdr_u, hdr_j} <= {hdr_e, hdr_u, hdr_j} | lo_jue;
            end
            if (hdr_wr && rom_addr == HDR_END) begin
                hdr_ready <= 1'b1;
            end
        end
    end

    // host streams rom words only inside a download window
    a_wr_in_download: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        rom_wr |-> cart_download);

endmodule

`default_nettype wire

// ==== sim.f ====
logic/core_pkg.sv
logic/rom_header_decode.sv
logic/cart_quirk_lookup.sv
logic/region_select.sv
logic/core_settings.sv
logic/pad_mapper.sv
logic/core_top.sv
tb/tb_core_top.sv

// ==== tb/tb_core_top.sv ====
/*
 * Directed testbench for core_top.
 * Streams cartridge headers, drives the bridge and the pads,
 * and checks quirks, region choice, console reset and pad words.
 */
`default_nettype none

module tb_core_top;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    logic                   clk_74a;
    logic                   pll_core_locked;
    logic [BRIDGE_W-1:0]    bridge_addr;
    logic                   bridge_wr;
    logic [BRIDGE_W-1:0]    bridge_wr_data;
    logic                   cart_download;
    logic                   rom_wr;
    logic [ROM_ADDR_W-1:0]  rom_addr;
    logic [ROM_DATA_W-1:0]  rom_data;
    logic                   osnotify_inmenu;
    logic [KEY_W-1:0]       cont1_key;
    logic [KEY_W-1:0]       cont2_key;
    logic [KEY_W-1:0]       cont3_key;
    logic [KEY_W-1:0]       cont4_key;
    logic [BRIDGE_W-1:0]    bridge_rd_data;
    logic [REGION_W-1:0]    region_req;
    logic [QUIRK_W-1:0]     quirk_flags;
    logic                   gun_type;
    logic [GUN_DELAY_W-1:0] gun_delay;
    logic                   core_reset_n;
    logic                   pause_en;
    logic [1:0]             cpu_turbo;
    logic                   multitap_en;
    logic [PAD_W-1:0]       pad0;
    logic [PAD_W-1:0]       pad1;
    logic [PAD_W-1:0]       pad2;
    logic [PAD_W-1:0]       pad3;

    int errors;

    core_top dut0 (.*);

    initial begin
        clk_74a = 1'b0;
        forever #4 clk_74a = ~clk_74a;  // 125 MHz stand-in
    end

    ////////////////////////////////////////
    // compare tasks

    task automatic check_region(input string name, input logic [REGION_W-1:0] exp, act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_quirk(input string name, input logic [QUIRK_W-1:0] exp, act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_pad(input string name, input logic [PAD_W-1:0] exp, act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [BRIDGE_W-1:0] exp, act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_delay(input string name, input logic [GUN_DELAY_W-1:0] exp, act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_turbo(input string name, input logic [1:0] exp, act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // expected values and bus helpers

    // console pad word from the button tables, Z down to right
    function automatic logic [PAD_W-1:0] expected_pad(input logic [KEY_W-1:0] k,
                                                      input logic alt,
                                                      input logic gun);
        logic [PAD_W-1:0] p;
        int z;
        int y;
        int x;
        int b;
        int a;
        z = alt ? 10 : 9;
        y = alt ? 7 : 6;
        x = alt ? 6 : 8;
        b = alt ? 11 : 4;
        a = alt ? 4 : 7;
        p[11] = k[z];
        p[10] = k[y];
        p[9]  = k[x];
        p[8]  = k[14];              // mode
        p[7]  = gun ? 1'b0 : k[15]; // start
        p[6]  = k[b];
        p[5]  = k[5];               // C is the same in both layouts
        p[4]  = k[a];
        p[3]  = k[0];
        p[2]  = k[1];
        p[1]  = k[2];
        p[0]  = k[3];
        return p;
    endfunction

    function automatic logic [QUIRK_W-1:0] quirk_bit(input int idx);
        logic [QUIRK_W-1:0] q;
        q      = '0;
        q[idx] = 1'b1;
        return q;
    endfunction

    task automatic bridge_write(input logic [BRIDGE_W-1:0] addr, data);
        @(posedge clk_74a);
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        bridge_wr      <= 1'b1;
        @(posedge clk_74a);
        bridge_wr <= 1'b0;
        @(negedge clk_74a);         // settings visible here
    endtask

    task automatic bridge_read_check(input string name, input logic [BRIDGE_W-1:0] addr, exp);
        @(posedge clk_74a);
        bridge_addr <= addr;
        @(negedge clk_74a);
        check_word(name, exp, bridge_rd_data);
    endtask

    task automatic rom_write(input logic [ROM_ADDR_W-1:0] addr, input logic [ROM_DATA_W-1:0] data);
        @(posedge clk_74a);
        rom_addr <= addr;
        rom_data <= data;
        rom_wr   <= 1'b1;
        @(posedge clk_74a);
        rom_wr <= 1'b0;
    endtask

    task automatic wait_reset(input string name, input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (core_reset_n !== level && cycles < limit) begin
            @(negedge clk_74a);
            cycles++;
        end
        if (core_reset_n !== level) begin
            errors++;
            $display("%s: core_reset_n did not go to %0b within %0d cycles", name, level, limit);
        end
    endtask

    ////////////////////////////////////////
    // tests

    task automatic test_reset_values();
        check_region("reset region", REGION_US, region_req);
        check_quirk("reset quirks", '0, quirk_flags);
        check_delay("reset gun delay", 8'd44, gun_delay);
        check_flag("reset console reset", 1'b1, core_reset_n);
        check_turbo("reset turbo", 2'd0, cpu_turbo);
        check_pad("reset pad0", '0, pad0);
    endtask

    task automatic test_settings();
        bridge_write(ADDR_TURBO, 32'd2);
        check_turbo("turbo write", 2'd2, cpu_turbo);
        bridge_write(ADDR_MULTITAP, 32'd1);
        check_flag("multitap write", 1'b1, multitap_en);
        @(posedge clk_74a);
        osnotify_inmenu <= 1'b1;
        @(negedge clk_74a);
        check_flag("pause disabled", 1'b0, pause_en);
        bridge_write(ADDR_MENU_PAUSE, 32'd1);
        check_flag("pause enabled", 1'b1, pause_en);
        @(posedge clk_74a);
        osnotify_inmenu <= 1'b0;
        @(negedge clk_74a);
        check_flag("pause menu closed", 1'b0, pause_en);
        bridge_read_check("unmapped read", 32'h0000_1234, '0);
        bridge_read_check("turbo read", ADDR_TURBO, '0);
    endtask

    task automatic test_pads();
        logic [KEY_W-1:0] k [4];
        logic [31:0]      r;
        logic             alt;
        logic             gun;
        for (int mode = 0; mode < 4; mode++) begin
            alt = mode[0];
            gun = mode[1];
            bridge_write(ADDR_M30_MAP, {31'd0, alt});
            bridge_write(ADDR_LIGHTGUN, {31'd0, gun});
            repeat (8) begin
                for (int i = 0; i < 4; i++) begin
                    r    = $urandom();
                    k[i] = r[KEY_W-1:0];
                end
                @(posedge clk_74a);
                cont1_key <= k[0];
                cont2_key <= k[1];
                cont3_key <= k[2];
                cont4_key <= k[3];
                @(posedge clk_74a);
                @(negedge clk_74a);
                check_pad("pad0 map", expected_pad(k[0], alt, gun), pad0);
                check_pad("pad1 map", expected_pad(k[1], alt, 1'b0), pad1);
                check_pad("pad2 map", expected_pad(k[2], alt, 1'b0), pad2);
                check_pad("pad3 map", expected_pad(k[3], alt, 1'b0), pad3);
            end
        end
        bridge_write(ADDR_M30_MAP, 32'd0);
        bridge_write(ADDR_LIGHTGUN, 32'd0);
    endtask

    // one full download: id, quirk check, region bytes, region reset and release
    task automatic run_cart(input string name, input logic [CART_ID_W-1:0] id,
                            input logic [ROM_DATA_W-1:0] reg0, reg1,
                            input logic [QUIRK_W-1:0] exp_q, input logic exp_type,
                            input logic [GUN_DELAY_W-1:0] exp_delay,
                            input logic [REGION_W-1:0] exp_region);
        @(posedge clk_74a);
        cart_download <= 1'b1;
        rom_write(HDR_ID0, {id[63:56], 8'h20});   // byte 182 is not id
        rom_write(HDR_ID1, {id[47:40], id[55:48]});
        rom_write(HDR_ID2, {id[31:24], id[39:32]});
        rom_write(HDR_ID3, {id[15:8], id[23:16]});
        rom_write(HDR_ID4, {8'h20, id[7:0]});
        rom_write(HDR_ID_DONE, 16'h2020);
        @(posedge clk_74a);                         // second cycle after the write
        @(negedge clk_74a);
        check_quirk({name, " quirks"}, exp_q, quirk_flags);
        check_flag({name, " gun type"}, exp_type, gun_type);
        check_delay({name, " gun delay"}, exp_delay, gun_delay);
        rom_write(HDR_REGION0, reg0);
        rom_write(HDR_REGION1, reg1);
        rom_write(HDR_END, 16'h0000);
        wait_reset({name, " region reset"}, 1'b0, 20);
        check_region({name, " region"}, exp_region, region_req);
        bridge_read_check({name, " region read"}, ADDR_REGION, BRIDGE_W'(exp_region));
        repeat (4) @(negedge clk_74a);
        check_flag({name, " reset held"}, 1'b0, core_reset_n);
        @(posedge clk_74a);
        cart_download <= 1'b0;
        wait_reset({name, " reset release"}, 1'b1, 20);
    endtask

    task automatic test_quirks();
        run_cart("sram", "T-081276", "  ", "  ", quirk_bit(Q_SRAM), 1'b0, 8'd44, REGION_US);
        run_cart("sram00", " GM 0000", "  ", "  ", quirk_bit(Q_SRAM00), 1'b0, 8'd44, REGION_US);
        run_cart("eeprom", "G-4060  ", "  ", "  ", quirk_bit(Q_EEPROM), 1'b0, 8'd44, REGION_US);
        run_cart("noram", "T-113016", "  ", "  ", quirk_bit(Q_NORAM), 1'b0, 8'd44, REGION_US);
        run_cart("fifo", "T-89016 ", "  ", "  ", quirk_bit(Q_FIFO), 1'b0, 8'd44, REGION_US);
        run_cart("pier", "T-574023", "  ", "  ", quirk_bit(Q_PIER), 1'b0, 8'd44, REGION_US);
        run_cart("svp", "MK-1229 ", "  ", "  ", quirk_bit(Q_SVP), 1'b0, 8'd44, REGION_US);
        run_cart("fmbusy", "T-35036 ", "  ", "  ", quirk_bit(Q_FMBUSY), 1'b0, 8'd44, REGION_US);
        run_cart("schan", "T-68???-", "  ", "  ", quirk_bit(Q_SCHAN), 1'b0, 8'd44, REGION_US);
        run_cart("gun mk1533", "MK-1533 ", "  ", "  ", '0, 1'b0, 8'd100, REGION_US);
        run_cart("gun t95096", "T-95096-", "  ", "  ", '0, 1'b1, 8'd52, REGION_US);
        run_cart("gun t95136", "T-95136-", "  ", "  ", '0, 1'b1, 8'd30, REGION_US);
        run_cart("unknown id", "T-00001 ", "  ", "  ", '0, 1'b0, 8'd44, REGION_US);
    endtask

    // word data is {odd byte, even byte}
    task automatic test_regions();
        run_cart("region JUE", "T-00001 ", "UJ", " E", '0, 1'b0, 8'd44, REGION_US);
        run_cart("region J", "T-00001 ", " J", "  ", '0, 1'b0, 8'd44, REGION_JP);
        run_cart("region E", "T-00001 ", " E", "  ", '0, 1'b0, 8'd44, REGION_EU);
        run_cart("region hex 4", "T-00001 ", " 4", "  ", '0, 1'b0, 8'd44, REGION_US);
        run_cart("region hex A", "T-00001 ", " A", "  ", '0, 1'b0, 8'd44, REGION_EU);
        run_cart("region none", "T-00001 ", "  ", "  ", '0, 1'b0, 8'd44, REGION_US);
    endtask

    task automatic test_host_reset();
        logic held;
        held = 1'b1;
        @(posedge clk_74a);
        osnotify_inmenu <= 1'b1;
        bridge_write(ADDR_RESET_REQ, 32'd1);
        check_flag("host reset asserted", 1'b0, core_reset_n);
        // longer than the largest delay, so any count inside the menu shows
        repeat (66000) begin
            @(negedge clk_74a);
            if (core_reset_n !== 1'b0) begin
                held = 1'b0;
            end
        end
        if (!held) begin
            errors++;
            $display("host reset: core_reset_n went high while the menu was open");
        end
        @(posedge clk_74a);
        osnotify_inmenu <= 1'b0;
        wait_reset("host reset release", 1'b1, 70000);  // delay is at most 16 bits
    endtask

    ////////////////////////////////////////
    // main sequence

    initial begin
        errors = 0;
        void'($urandom(23339));
        pll_core_locked = 1'b0;
        bridge_addr     = '0;
        bridge_wr       = 1'b0;
        bridge_wr_data  = '0;
        cart_download   = 1'b0;
        rom_wr          = 1'b0;
        rom_addr        = '0;
        rom_data        = '0;
        osnotify_inmenu = 1'b0;
        cont1_key       = '0;
        cont2_key       = '0;
        cont3_key       = '0;
        cont4_key       = '0;
        repeat (16) @(posedge clk_74a);
        pll_core_locked <= 1'b1;
        @(negedge clk_74a);

        test_reset_values();
        test_settings();
        test_pads();
        test_quirks();
        test_regions();
        test_host_reset();

        $display("tb_core_top done, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
